// ==== Bender.yml ====
package:
  name: dma_wrap

sources:
  - src/dma_pkg.sv
  - src/dma_reg_frontend.sv
  - src/dma_transfer_id_gen.sv
  - src/dma_job_fifo.sv
  - src/dma_page_splitter.sv
  - src/dma_copy_backend.sv
  - src/dma_rsp_merge.sv
  - src/dma_wrap.sv
  - target: simulation
    files:
      - sim/tb_dma_wrap.sv

// ==== dma_wrap.f ====
src/dma_pkg.sv
src/dma_reg_frontend.sv
src/dma_transfer_id_gen.sv
src/dma_job_fifo.sv
src/dma_page_splitter.sv
src/dma_copy_backend.sv
src/dma_rsp_merge.sv
src/dma_wrap.sv
sim/tb_dma_wrap.sv

// ==== sim/tb_dma_wrap.sv ====
`timescale 1ns/1ps

module tb_dma_wrap;

  // The tests need about 1200 cycles of traffic in all
  localparam int unsigned MaxCycles = 20000;

  logic        clk_i, rst_n_i, reg_req_i, reg_we_i, reg_ready_o;
  logic [31:0] reg_addr_i, reg_wdata_i, reg_rdata_o;
  logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i, mem_err_i;
  logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;

  logic [31:0] mem [16384];
  integer      seed = 77;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          stalls = 0;
  logic        no_mem = 1'b0;
  logic        range_on = 1'b0;
  logic [31:0] range_src, range_dst, range_len;

  dma_wrap #(.JobFifoDepth(4)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Memory model that always grants and responds one cycle after the grant
  assign mem_gnt_i = 1'b1;

  always @(posedge clk_i) begin : mem_model
    logic        req;
    logic [31:0] addr;
    logic [31:0] rdata;
    req   = mem_req_o;
    addr  = mem_addr_o;
    rdata = mem[addr[15:2]];
    if (req && mem_we_o) begin
      mem[addr[15:2]] = mem_wdata_o;
    end
    #10;
    mem_rvalid_i = req;
    mem_rdata_i  = rdata;
    mem_err_i    = req && (addr >= 32'h0001_0000);
  end

  // Accesses must stay inside the source and destination buffers
  always @(posedge clk_i) begin
    if (range_on && mem_req_o) begin
      assert (mem_we_o ? (mem_addr_o - range_dst < range_len)
                       : (mem_addr_o - range_src < range_len))
      else begin
        $display("memory access at %h falls outside the copy buffers at %0t ns",
                 mem_addr_o, $time);
        errors++;
      end
    end
  end

  assert property (@(posedge clk_i) !(no_mem && mem_req_o))
  else begin
    $display("memory request seen during the zero-length transfer at %0t ns", $time);
    errors++;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Called 10 ns after a rising edge and returns at the same point
  task automatic reg_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    logic done;
    reg_req_i   = 1'b1;
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    done        = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done  = reg_ready_o;
      rdata = reg_rdata_o;
      if (!done) begin
        stalls++;
      end
      @(posedge clk_i);
      #10;
    end
    reg_req_i = 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
    reg_access(1'b0, addr, '0, data);
  endtask

  task automatic launch(input logic [31:0] src, input logic [31:0] dst,
                        input logic [31:0] len, output logic [31:0] id);
    reg_write(dma_pkg::RegSrc, src);
    reg_write(dma_pkg::RegDst, dst);
    reg_write(dma_pkg::RegLen, len);
    reg_read(dma_pkg::RegLaunch, id);
  endtask

  task automatic wait_done(input logic [31:0] id);
    logic [31:0] done_id;
    reg_read(dma_pkg::RegDone, done_id);
    while (done_id != id) begin
      reg_read(dma_pkg::RegDone, done_id);
    end
  endtask

  task automatic check_copy(input logic [31:0] src, input logic [31:0] dst,
                            input logic [31:0] len);
    for (int i = 0; i < len / 4; i++) begin
      check_val($sformatf("mem[%h]", dst + 4 * i), mem[(src >> 2) + i], mem[(dst >> 2) + i]);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    $display("test %s: %s", name, (errors == errors_before) ? "ok" : "mismatches found");
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] id;
    logic [31:0] ids [6];
    logic [31:0] exp_id;
    int          mark;
    reg_req_i    = 1'b0;
    reg_we_i     = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_err_i    = 1'b0;
    for (int i = 0; i < 16384; i++) begin
      mem[i] = $random(seed);
    end
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    // IDs are handed out from 1 upwards
    exp_id = 32'd1;

    mark = errors;
    reg_read(dma_pkg::RegStatus, rd);
    check_val("RegStatus", 32'h0, rd);
    reg_write(dma_pkg::RegSrc, 32'hA5A5_0004);
    reg_write(dma_pkg::RegDst, 32'h5A5A_1008);
    reg_write(dma_pkg::RegLen, 32'h0000_0FFC);
    reg_read(dma_pkg::RegSrc, rd);
    check_val("RegSrc", 32'hA5A5_0004, rd);
    reg_read(dma_pkg::RegDst, rd);
    check_val("RegDst", 32'h5A5A_1008, rd);
    reg_read(dma_pkg::RegLen, rd);
    check_val("RegLen", 32'h0000_0FFC, rd);
    end_test("register readback", mark);

    mark = errors;
    launch(32'h0100, 32'h4100, 64, id);
    check_val("launch ID", exp_id, id);
    wait_done(exp_id);
    check_copy(32'h0100, 32'h4100, 64);
    reg_read(dma_pkg::RegStatus, rd);
    check_val("RegStatus", 32'h0, rd);
    exp_id++;
    end_test("single-page copy", mark);

    mark = errors;
    range_src = 32'h0FF0;
    range_dst = 32'h2FF8;
    range_len = 48;
    range_on  = 1'b1;
    launch(32'h0FF0, 32'h2FF8, 48, id);
    check_val("launch ID", exp_id, id);
    wait_done(exp_id);
    range_on = 1'b0;
    check_copy(32'h0FF0, 32'h2FF8, 48);
    // Three fragments still retire only once
    reg_read(dma_pkg::RegDone, rd);
    check_val("RegDone", exp_id, rd);
    exp_id++;
    end_test("page-crossing copy", mark);

    // The first job spans two source pages and holds the splitter, so the FIFO fills
    mark = errors;
    stalls = 0;
    for (int k = 0; k < 6; k++) begin
      launch(32'h4FE0 + k * 32'h200, 32'h8000 + k * 32'h200, 64 + k * 32, ids[k]);
      check_val("launch ID", exp_id + k, ids[k]);
    end
    checks++;
    assert (stalls > 0)
    else begin
      $display("the launches never stalled on a full job FIFO");
      errors++;
    end
    exp_id = exp_id + 5;
    wait_done(exp_id);
    reg_read(dma_pkg::RegDone, rd);
    check_val("RegDone", exp_id, rd);
    for (int k = 0; k < 6; k++) begin
      check_copy(32'h4FE0 + k * 32'h200, 32'h8000 + k * 32'h200, 64 + k * 32);
    end
    exp_id++;
    end_test("back-pressure and IDs", mark);

    mark = errors;
    launch(32'h0001_0000, 32'hA000, 16, id);
    check_val("launch ID", exp_id, id);
    wait_done(exp_id);
    exp_id++;
    reg_read(dma_pkg::RegStatus, rd);
    check_val("RegStatus", 32'h2, rd);
    launch(32'h0200, 32'hB000, 16, id);
    check_val("launch ID", exp_id, id);
    wait_done(exp_id);
    exp_id++;
    reg_read(dma_pkg::RegStatus, rd);
    check_val("RegStatus", 32'h0, rd);
    end_test("error flag", mark);

    mark = errors;
    no_mem = 1'b1;
    launch(32'hC000, 32'hD000, 0, id);
    check_val("launch ID", exp_id, id);
    wait_done(exp_id);
    no_mem = 1'b0;
    end_test("zero length", mark);

    $display("tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src/dma_copy_backend.sv ====
`timescale 1ns/1ps

module dma_copy_backend (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  dma_pkg::dma_frag_t            frag_i,
  input  logic                          frag_valid_i,
  output logic                          frag_ready_o,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_addr_o,
  output logic [dma_pkg::DataWidth-1:0] mem_wdata_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic [dma_pkg::DataWidth-1:0] mem_rdata_i,
  input  logic                          mem_err_i,
  output logic                          rsp_valid_o,
  output logic                          rsp_err_o,
  output logic                          rsp_last_o,
  output logic                          busy_o
);

  localparam int unsigned WordBytes = dma_pkg::DataWidth / 8;

  typedef enum logic [2:0] {
    Idle,
    Read,
    WaitRead,
    Write,
    WaitWrite
  } state_e;

  state_e                       state_q;
  dma_pkg::addr_u               src_q;
  dma_pkg::addr_u               dst_q;
  logic [dma_pkg::LenWidth-1:0] len_q;
  logic [dma_pkg::DataWidth-1:0] data_q;
  logic                         last_q;
  logic                         err_q;
  logic                         rsp_valid_q;

  assign frag_ready_o = (state_q == Idle);
  assign busy_o       = (state_q != Idle);
  assign mem_req_o    = (state_q == Read) || (state_q == Write);
  assign mem_we_o     = (state_q == Write);
  assign mem_addr_o   = (state_q == Write) ? dst_q.raw : src_q.raw;
  assign mem_wdata_o  = data_q;
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_err_o    = err_q;
  assign rsp_last_o   = last_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= Idle;
      rsp_valid_q <= 1'b0;
      err_q       <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        Idle: begin
          if (frag_valid_i) begin
            err_q  <= 1'b0;
            last_q <= frag_i.last;
            // An empty fragment answers right away without a memory access
            if (frag_i.job.len == '0) begin
              rsp_valid_q <= 1'b1;
            end else begin
              state_q <= Read;
            end
          end
        end
        Read: begin
          if (mem_gnt_i) begin
            state_q <= WaitRead;
          end
        end
        WaitRead: begin
          if (mem_rvalid_i) begin
            err_q   <= err_q | mem_err_i;
            state_q <= Write;
          end
        end
        Write: begin
          if (mem_gnt_i) begin
            state_q <= WaitWrite;
          end
        end
        WaitWrite: begin
          if (mem_rvalid_i) begin
            err_q <= err_q | mem_err_i;
            if (len_q == dma_pkg::LenWidth'(WordBytes)) begin
              state_q     <= Idle;
              rsp_valid_q <= 1'b1;
            end else begin
              state_q <= Read;
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Address, length and data path
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && frag_valid_i) begin
      src_q <= frag_i.job.src;
      dst_q <= frag_i.job.dst;
      len_q <= frag_i.job.len;
    end else if (state_q == WaitWrite && mem_rvalid_i) begin
      src_q.raw <= src_q.raw + dma_pkg::AddrWidth'(WordBytes);
      dst_q.raw <= dst_q.raw + dma_pkg::AddrWidth'(WordBytes);
      len_q     <= len_q - dma_pkg::LenWidth'(WordBytes);
    end
    if (state_q == WaitRead && mem_rvalid_i) begin
      data_q <= mem_rdata_i;
    end
  end

endmodule

// ==== src/dma_job_fifo.sv ====
`timescale 1ns/1ps

module dma_job_fifo #(
  parameter int unsigned Depth = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  dma_pkg::dma_job_t data_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_job_t data_o,
  output logic              valid_o,
  input  logic              ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  dma_pkg::dma_job_t     mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== src/dma_page_splitter.sv ====
`timescale 1ns/1ps

module dma_page_splitter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  dma_pkg::dma_job_t  job_i,
  input  logic               job_valid_i,
  output logic               job_ready_o,
  output dma_pkg::dma_frag_t frag_o,
  output logic               frag_valid_o,
  input  logic               frag_ready_i
);

  localparam int unsigned PageBytes = 1 << dma_pkg::PageOffsetWidth;
  localparam int unsigned RemWidth  = dma_pkg::PageOffsetWidth + 1;

  logic                         active_q;
  dma_pkg::dma_job_t            cur_q;
  logic [RemWidth-1:0]          src_rem;
  logic [RemWidth-1:0]          dst_rem;
  logic [RemWidth-1:0]          page_rem;
  logic [dma_pkg::LenWidth-1:0] frag_len;
  logic                         frag_last;
  logic                         frag_fire;

  // Bytes left until the end of the current page on each side
  assign src_rem  = RemWidth'(PageBytes) - {1'b0, cur_q.src.page.offset};
  assign dst_rem  = RemWidth'(PageBytes) - {1'b0, cur_q.dst.page.offset};
  assign page_rem = (src_rem < dst_rem) ? src_rem : dst_rem;

  always_comb begin
    if (cur_q.len <= dma_pkg::LenWidth'(page_rem)) begin
      frag_len  = cur_q.len;
      frag_last = 1'b1;
    end else begin
      frag_len  = dma_pkg::LenWidth'(page_rem);
      frag_last = 1'b0;
    end
  end

  assign frag_o.job.src = cur_q.src;
  assign frag_o.job.dst = cur_q.dst;
  assign frag_o.job.len = frag_len;
  assign frag_o.last    = frag_last;
  assign frag_valid_o   = active_q;

  // Next job is taken once the last fragment of this one has left
  assign job_ready_o = ~active_q;
  assign frag_fire   = frag_valid_o & frag_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else if (job_valid_i && job_ready_o) begin
      active_q <= 1'b1;
    end else if (frag_fire && frag_last) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_valid_i && job_ready_o) begin
      cur_q <= job_i;
    end else if (frag_fire) begin
      cur_q.src.raw <= cur_q.src.raw + frag_len;
      cur_q.dst.raw <= cur_q.dst.raw + frag_len;
      cur_q.len     <= cur_q.len - frag_len;
    end
  end

endmodule

// ==== src/dma_pkg.sv ====
package dma_pkg;

  // Bus and counter widths
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned DataWidth       = 32;
  localparam int unsigned LenWidth        = 32;
  localparam int unsigned IdWidth         = 32;
  localparam int unsigned PageOffsetWidth = 12;

  // Register byte offsets
  localparam logic [AddrWidth-1:0] RegSrc    = 'h00;
  localparam logic [AddrWidth-1:0] RegDst    = 'h04;
  localparam logic [AddrWidth-1:0] RegLen    = 'h08;
  localparam logic [AddrWidth-1:0] RegLaunch = 'h10;
  localparam logic [AddrWidth-1:0] RegDone   = 'h14;
  localparam logic [AddrWidth-1:0] RegStatus = 'h18;

  // Address split into page number and in-page offset
  typedef struct packed {
    logic [AddrWidth-PageOffsetWidth-1:0] pfn;
    logic [PageOffsetWidth-1:0]           offset;
  } page_addr_t;

  typedef union packed {
    logic [AddrWidth-1:0] raw;
    page_addr_t           page;
  } addr_u;

  // One transfer as launched by software
  typedef struct packed {
    addr_u               src;
    addr_u               dst;
    logic [LenWidth-1:0] len;
  } dma_job_t;

  // Page-bounded piece of a transfer
  typedef struct packed {
    dma_job_t job;
    logic     last;
  } dma_frag_t;

endpackage

// ==== src/dma_reg_frontend.sv ====
`timescale 1ns/1ps

module dma_reg_frontend (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [dma_pkg::AddrWidth-1:0] reg_addr_i,
  input  logic [dma_pkg::DataWidth-1:0] reg_wdata_i,
  output logic [dma_pkg::DataWidth-1:0] reg_rdata_o,
  output logic                          reg_ready_o,
  output dma_pkg::dma_job_t             job_o,
  output logic                          job_valid_o,
  input  logic                          job_ready_i,
  input  logic [dma_pkg::IdWidth-1:0]   next_id_i,
  input  logic [dma_pkg::IdWidth-1:0]   done_id_i,
  input  logic                          retire_i,
  input  logic                          retire_err_i,
  input  logic                          busy_i
);

  dma_pkg::addr_u             src_q;
  dma_pkg::addr_u             dst_q;
  logic [dma_pkg::LenWidth-1:0] len_q;
  logic                       err_q;
  logic                       launch_rd;

  // A launch is a read of the launch register
  assign launch_rd = reg_req_i & ~reg_we_i & (reg_addr_i == dma_pkg::RegLaunch);

  assign job_valid_o = launch_rd;
  assign job_o.src   = src_q;
  assign job_o.dst   = dst_q;
  assign job_o.len   = len_q;

  // Stall only the launch read, and only while the job FIFO is full
  assign reg_ready_o = ~launch_rd | job_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q.raw <= '0;
      dst_q.raw <= '0;
      len_q     <= '0;
    end else if (reg_req_i && reg_we_i) begin
      case (reg_addr_i)
        dma_pkg::RegSrc: src_q.raw <= reg_wdata_i;
        dma_pkg::RegDst: dst_q.raw <= reg_wdata_i;
        dma_pkg::RegLen: len_q     <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Error of the most recently retired transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (retire_i) begin
      err_q <= retire_err_i;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      dma_pkg::RegSrc:    reg_rdata_o = src_q.raw;
      dma_pkg::RegDst:    reg_rdata_o = dst_q.raw;
      dma_pkg::RegLen:    reg_rdata_o = len_q;
      dma_pkg::RegLaunch: reg_rdata_o = next_id_i;
      dma_pkg::RegDone:   reg_rdata_o = done_id_i;
      dma_pkg::RegStatus: begin
        reg_rdata_o[0] = busy_i;
        reg_rdata_o[1] = err_q;
      end
      default: ;
    endcase
  end

endmodule

// ==== src/dma_rsp_merge.sv ====
`timescale 1ns/1ps

module dma_rsp_merge (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic rsp_valid_i,
  input  logic rsp_err_i,
  input  logic rsp_last_i,
  output logic retire_o,
  output logic retire_err_o
);

  logic err_q;

  // One retire per transfer, on its last fragment
  assign retire_o     = rsp_valid_i & rsp_last_i;
  assign retire_err_o = err_q | rsp_err_i;

  // Sticky across fragments, cleared once the transfer retires
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (rsp_valid_i) begin
      if (rsp_last_i) begin
        err_q <= 1'b0;
      end else begin
        err_q <= err_q | rsp_err_i;
      end
    end
  end

endmodule

// ==== src/dma_transfer_id_gen.sv ====
`timescale 1ns/1ps

module dma_transfer_id_gen (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        issue_i,
  input  logic                        retire_i,
  output logic [dma_pkg::IdWidth-1:0] next_id_o,
  output logic [dma_pkg::IdWidth-1:0] done_id_o
);

  logic [dma_pkg::IdWidth-1:0] next_q;
  logic [dma_pkg::IdWidth-1:0] done_q;

  // Both counters wrap; ID 0 means nothing has retired yet
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      next_q <= dma_pkg::IdWidth'(1);
      done_q <= '0;
    end else begin
      if (issue_i) begin
        next_q <= next_q + 1'b1;
      end
      if (retire_i) begin
        done_q <= done_q + 1'b1;
      end
    end
  end

  assign next_id_o = next_q;
  assign done_id_o = done_q;

endmodule

// ==== src/dma_wrap.sv ====
`timescale 1ns/1ps

module dma_wrap #(
  parameter int unsigned JobFifoDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          reg_req_i,
  input  logic                          reg_we_i,
  input  logic [dma_pkg::AddrWidth-1:0] reg_addr_i,
  input  logic [dma_pkg::DataWidth-1:0] reg_wdata_i,
  output logic [dma_pkg::DataWidth-1:0] reg_rdata_o,
  output logic                          reg_ready_o,
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [dma_pkg::AddrWidth-1:0] mem_addr_o,
  output logic [dma_pkg::DataWidth-1:0] mem_wdata_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic [dma_pkg::DataWidth-1:0] mem_rdata_i,
  input  logic                          mem_err_i
);

  // Frontend to FIFO
  dma_pkg::dma_job_t job_fe;
  logic              job_fe_valid, job_fe_ready, job_issue;
  // FIFO to splitter
  dma_pkg::dma_job_t job_q;
  logic              job_q_valid, job_q_ready;
  // Splitter to backend
  dma_pkg::dma_frag_t frag;
  logic               frag_valid, frag_ready;
  // Responses and IDs
  logic rsp_valid, rsp_err, rsp_last, retire, retire_err, be_busy;
  logic [dma_pkg::IdWidth-1:0] next_id, done_id;

  assign job_issue = job_fe_valid & job_fe_ready;

  dma_reg_frontend i_frontend (
    .clk_i, .rst_n_i, .reg_req_i, .reg_we_i, .reg_addr_i, .reg_wdata_i,
    .reg_rdata_o, .reg_ready_o,
    .job_o        ( job_fe       ), .job_valid_o ( job_fe_valid ), .job_ready_i ( job_fe_ready ),
    .next_id_i    ( next_id      ), .done_id_i   ( done_id      ),
    .retire_i     ( retire       ), .retire_err_i ( retire_err  ), .busy_i      ( be_busy      )
  );

  dma_transfer_id_gen i_id_gen (
    .clk_i, .rst_n_i,
    .issue_i ( job_issue ), .retire_i ( retire ), .next_id_o ( next_id ), .done_id_o ( done_id )
  );

  dma_job_fifo #(.Depth ( JobFifoDepth )) i_job_fifo (
    .clk_i, .rst_n_i,
    .data_i ( job_fe ), .valid_i ( job_fe_valid ), .ready_o ( job_fe_ready ),
    .data_o ( job_q  ), .valid_o ( job_q_valid  ), .ready_i ( job_q_ready  )
  );

  dma_page_splitter i_splitter (
    .clk_i, .rst_n_i,
    .job_i  ( job_q ), .job_valid_i  ( job_q_valid ), .job_ready_o  ( job_q_ready ),
    .frag_o ( frag  ), .frag_valid_o ( frag_valid  ), .frag_ready_i ( frag_ready  )
  );

  dma_copy_backend i_backend (
    .clk_i, .rst_n_i,
    .frag_i ( frag ), .frag_valid_i ( frag_valid ), .frag_ready_o ( frag_ready ),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i, .mem_err_i,
    .rsp_valid_o ( rsp_valid ), .rsp_err_o ( rsp_err ), .rsp_last_o ( rsp_last ),
    .busy_o      ( be_busy   )
  );

  dma_rsp_merge i_rsp_merge (
    .clk_i, .rst_n_i,
    .rsp_valid_i ( rsp_valid ), .rsp_err_i ( rsp_err ), .rsp_last_i ( rsp_last ),
    .retire_o    ( retire    ), .retire_err_o ( retire_err )
  );

endmodule
